// File: src/scomp_pkg.sv
// Shared widths, opcodes and state encoding for the accumulator computer
// Memory size and program file name

package scomp_pkg;

	localparam int word_width = 16;           // Data and instruction word
	localparam int addr_width = 8;            // Memory address and program counter
	localparam int digit_count = 4;           // Hex digits on the readout

	typedef logic [word_width-1:0] word_t;    // One memory word
	typedef logic [addr_width-1:0] addr_t;    // One memory address
	typedef logic [7:0] opcode_t;             // Upper byte of an instruction
	typedef logic [3:0] digit_t;              // One hex nibble
	typedef logic [6:0] segments_t;           // Active-low, segment a in bit 0
	typedef logic [2:0] display_select_t;     // Readout source select

	////////////////////////////////
	// Instruction set
	////////////////////////////////
	localparam opcode_t opcode_add = 8'h00;           // A = A + mem[addr]
	localparam opcode_t opcode_store = 8'h01;         // mem[addr] = A
	localparam opcode_t opcode_load = 8'h02;          // A = mem[addr]
	localparam opcode_t opcode_jump = 8'h03;          // PC = addr
	localparam opcode_t opcode_jump_negative = 8'h04; // PC = addr when A < 0
	localparam opcode_t opcode_out = 8'h05;           // Out = A

	// Instruction cycle states
	typedef enum logic [3:0] {
		reset_pc       = 4'h0,
		fetch          = 4'h1,
		decode         = 4'h2,
		execute_add    = 4'h3,
		execute_store  = 4'h4,
		execute_store2 = 4'h5,
		execute_store3 = 4'h6,
		execute_load   = 4'h7,
		execute_jump   = 4'h8,
		execute_jump_n = 4'h9,
		execute_out    = 4'ha
	} scomp_state_t;

	localparam int memory_words = 256;        // Full 8-bit address space
	localparam program_file = "program.hex";  // Initial program and data

endpackage

// File: src/scomp_control.sv
// Instruction cycle FSM for the accumulator computer
// Decodes every datapath strobe from the current state

`timescale 1ns/1ps

module scomp_control import scomp_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  opcode_t opcode,               // From instruction register
	input  logic    accumulator_negative, // Sign of A
	output logic    ir_load,
	output logic    pc_clear,
	output logic    pc_increment,
	output logic    pc_load,
	output logic    operand_select,       // Address from IR operand byte
	output logic    acc_clear,
	output logic    acc_add,
	output logic    acc_load,
	output logic    out_load,
	output logic    memory_write
);

	scomp_state_t state;
	scomp_state_t state_next;
	logic         opcode_defined;

	// Opcodes above 5 fall back to fetch
	assign opcode_defined = (opcode <= opcode_out);

	////////////////////////////////
	// State register
	////////////////////////////////
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			state <= reset_pc;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = fetch; // Most states return to fetch
		case (state)
			reset_pc:       state_next = fetch;
			fetch:          state_next = decode;
			decode:
			begin
				case (opcode)
					opcode_add:           state_next = execute_add;
					opcode_store:         state_next = execute_store;
					opcode_load:          state_next = execute_load;
					opcode_jump:          state_next = execute_jump;
					opcode_jump_negative: state_next = execute_jump_n;
					opcode_out:           state_next = execute_out;
					default:              state_next = fetch; // Undefined opcode skips execute
				endcase
			end
			execute_store:  state_next = execute_store2;
			execute_store2: state_next = execute_store3;
			default:        state_next = fetch;
		endcase
	end

	////////////////////////////////
	// Strobe decode
	////////////////////////////////
	always_comb
	begin
		ir_load        = 1'b0;
		pc_clear       = 1'b0;
		pc_increment   = 1'b0;
		pc_load        = 1'b0;
		operand_select = 1'b0;
		acc_clear      = 1'b0;
		acc_add        = 1'b0;
		acc_load       = 1'b0;
		out_load       = 1'b0;
		memory_write   = 1'b0;
		case (state)
			reset_pc:
			begin
				pc_clear  = 1'b1;
				acc_clear = 1'b1; // Also clears the output register
			end
			fetch:
			begin
				ir_load      = 1'b1;
				pc_increment = 1'b1;
			end
			decode:         operand_select = opcode_defined; // Prefetch operand word
			execute_add:    acc_add = 1'b1;
			execute_store:
			begin
				operand_select = 1'b1;
				memory_write   = 1'b1; // Written at the edge leaving this state
			end
			execute_store2: operand_select = 1'b1; // Hold write address
			execute_load:   acc_load = 1'b1;
			execute_jump:
			begin
				pc_load        = 1'b1;
				operand_select = 1'b1; // Next fetch reads the target
			end
			execute_jump_n:
			begin
				pc_load        = accumulator_negative;
				operand_select = accumulator_negative;
			end
			execute_out:    out_load = 1'b1;
			default:        ;
		endcase
	end

	// Only a store instruction writes memory
	assert property (@(posedge clock) disable iff (reset)
		memory_write |-> (state == execute_store) && (opcode == opcode_store));

	// Accumulator sees one operation at a time
	assert property (@(posedge clock) disable iff (reset)
		$onehot0({acc_clear, acc_add, acc_load}));

endmodule

// File: src/address_unit.sv
// Program counter, instruction register and memory address mux

`timescale 1ns/1ps

module address_unit import scomp_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  logic    ir_load,
	input  logic    pc_clear,
	input  logic    pc_increment,
	input  logic    pc_load,
	input  logic    operand_select,
	input  word_t   memory_data,
	output opcode_t opcode,
	output addr_t   program_counter,
	output word_t   instruction_register,
	output addr_t   memory_address
);

	addr_t operand; // Low byte of the instruction

	assign operand = instruction_register[7:0];
	assign opcode  = instruction_register[15:8];

	// Operand byte or next instruction address
	assign memory_address = operand_select ? operand : program_counter;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			program_counter <= '0;
		else if (pc_clear)
			program_counter <= '0;
		else if (pc_load)
			program_counter <= operand; // Jump target
		else if (pc_increment)
			program_counter <= program_counter + 1'b1; // Wraps at 255
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			instruction_register <= '0;
		else if (ir_load)
			instruction_register <= memory_data; // Word read at fetch
	end

	// Control never jumps during a fetch
	assert property (@(posedge clock) disable iff (reset)
		!(pc_load && pc_increment));

endmodule

// File: src/accumulator_unit.sv
// Accumulator with add and load, and the output register

`timescale 1ns/1ps

module accumulator_unit import scomp_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  logic  acc_clear,
	input  logic  acc_add,
	input  logic  acc_load,
	input  logic  out_load,
	input  word_t memory_data,
	output word_t accumulator,
	output logic  accumulator_negative,
	output word_t out_register
);

	assign accumulator_negative = accumulator[15]; // Two's complement sign

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			accumulator <= '0;
		else if (acc_clear)
			accumulator <= '0;
		else if (acc_add)
			accumulator <= accumulator + memory_data; // Carry dropped
		else if (acc_load)
			accumulator <= memory_data;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			out_register <= '0;
		else if (acc_clear)
			out_register <= '0;
		else if (out_load)
			out_register <= accumulator; // OUT instruction
	end

endmodule

// File: src/program_memory.sv
// Single-port 256 x 16 memory with registered address
// Program and data come from the hex file at start-up

`timescale 1ns/1ps

module program_memory import scomp_pkg::*; (
	input  logic  clock,
	input  addr_t memory_address,
	input  logic  memory_write,
	input  word_t write_data,    // Accumulator value
	output word_t memory_data
);

	word_t memory [memory_words];
	addr_t read_address; // Address latched each edge

	initial
	begin
		$readmemh(program_file, memory);
	end

	always_ff @(posedge clock)
	begin
		if (memory_write)
			memory[memory_address] <= write_data;
		read_address <= memory_address;
	end

	// Reads the new word right after a write
	assign memory_data = memory[read_address];

endmodule

// File: src/hex_display.sv
// Readout source mux and seven-segment decoders for four hex digits

`timescale 1ns/1ps

module hex_display import scomp_pkg::*; (
	input  display_select_t display_select,
	input  word_t           accumulator,
	input  word_t           memory_data,
	input  word_t           instruction_register,
	input  word_t           out_register,
	input  addr_t           program_counter,
	output segments_t       hex0,
	output segments_t       hex1,
	output segments_t       hex2,
	output segments_t       hex3
);

	word_t     display_value;
	segments_t digit_segments [digit_count];

	// Board pattern, a segment lights on 0
	function automatic segments_t digit_to_segments(input digit_t digit);
		case (digit)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'ha: return 7'b0001000;
			4'hb: return 7'b0000011;
			4'hc: return 7'b1000110;
			4'hd: return 7'b0100001;
			4'he: return 7'b0000110;
			default: return 7'b0001110; // F
		endcase
	endfunction

	always_comb
	begin
		case (display_select)
			3'd0:    display_value = accumulator;
			3'd1:    display_value = {8'h00, program_counter}; // Zero-extended
			3'd2:    display_value = memory_data;
			3'd3:    display_value = instruction_register;
			3'd4:    display_value = out_register;
			default: display_value = accumulator;
		endcase
	end

	// One decoder per nibble, digit 0 is the lowest
	for (genvar i = 0; i < digit_count; i++)
	begin : gen_digit
		assign digit_segments[i] = digit_to_segments(display_value[i*4 +: 4]);
	end

	assign hex0 = digit_segments[0];
	assign hex1 = digit_segments[1];
	assign hex2 = digit_segments[2];
	assign hex3 = digit_segments[3];

endmodule

// File: src/scomp_top.sv
// Top level of the accumulator computer with its hex readout
// Control FSM, address and accumulator datapaths, memory, display

`timescale 1ns/1ps

module scomp_top import scomp_pkg::*; (
	input  logic            clock,
	input  logic            reset,
	input  display_select_t display_select,
	output segments_t       hex0,
	output segments_t       hex1,
	output segments_t       hex2,
	output segments_t       hex3,
	output addr_t           program_counter,
	output word_t           accumulator,
	output word_t           memory_data,
	output word_t           instruction_register,
	output word_t           out_register
);

	////////////////////////////////
	// Control strobes
	////////////////////////////////
	opcode_t opcode;
	logic    accumulator_negative;
	logic    ir_load;
	logic    pc_clear;
	logic    pc_increment;
	logic    pc_load;
	logic    operand_select;
	logic    acc_clear;
	logic    acc_add;
	logic    acc_load;
	logic    out_load;
	logic    memory_write;
	addr_t   memory_address; // Combinational, latched by memory

	scomp_control control_i (
		.clock                (clock),
		.reset                (reset),
		.opcode               (opcode),
		.accumulator_negative (accumulator_negative),
		.ir_load              (ir_load),
		.pc_clear             (pc_clear),
		.pc_increment         (pc_increment),
		.pc_load              (pc_load),
		.operand_select       (operand_select),
		.acc_clear            (acc_clear),
		.acc_add              (acc_add),
		.acc_load             (acc_load),
		.out_load             (out_load),
		.memory_write         (memory_write)
	);

	address_unit address_i (
		.clock                (clock),
		.reset                (reset),
		.ir_load              (ir_load),
		.pc_clear             (pc_clear),
		.pc_increment         (pc_increment),
		.pc_load              (pc_load),
		.operand_select       (operand_select),
		.memory_data          (memory_data),
		.opcode               (opcode),
		.program_counter      (program_counter),
		.instruction_register (instruction_register),
		.memory_address       (memory_address)
	);

	accumulator_unit accumulator_i (
		.clock                (clock),
		.reset                (reset),
		.acc_clear            (acc_clear),
		.acc_add              (acc_add),
		.acc_load             (acc_load),
		.out_load             (out_load),
		.memory_data          (memory_data),
		.accumulator          (accumulator),
		.accumulator_negative (accumulator_negative),
		.out_register         (out_register)
	);

	// ST writes the accumulator
	program_memory memory_i (
		.clock          (clock),
		.memory_address (memory_address),
		.memory_write   (memory_write),
		.write_data     (accumulator),
		.memory_data    (memory_data)
	);

	hex_display display_i (
		.display_select       (display_select),
		.accumulator          (accumulator),
		.memory_data          (memory_data),
		.instruction_register (instruction_register),
		.out_register         (out_register),
		.program_counter      (program_counter),
		.hex0                 (hex0),
		.hex1                 (hex1),
		.hex2                 (hex2),
		.hex3                 (hex3)
	);

endmodule

// File: dv/scomp_model.svh
// Cycle model of the accumulator computer, one step per clock edge
// Segment reference table for the hex readout

`ifndef scomp_model_svh
`define scomp_model_svh

word_t        ref_mem [memory_words];  // Own copy of program and data
word_t        ref_acc;
word_t        ref_ir;
word_t        ref_out;
addr_t        ref_pc;
addr_t        ref_read_address;        // Address latched by the memory
scomp_state_t ref_state;
logic         left_reset_pc;           // Set for the cycle after reset_pc

// Board pattern, active low, segment a in bit 0
localparam segments_t segment_table [16] = '{
	7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
	7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
};

task automatic load_program();
	$readmemh("program.hex", ref_mem);
	ref_read_address = '0;
endtask

// Reset clears registers and state, memory keeps its words
task automatic restart_cycle();
	ref_state     = reset_pc;
	ref_pc        = '0;
	ref_acc       = '0;
	ref_ir        = '0;
	ref_out       = '0;
	left_reset_pc = 1'b0;
endtask

// One clock edge, in_reset is the reset level before the edge
task automatic advance_cycle(input logic in_reset);
	word_t        data;
	addr_t        operand;
	addr_t        address;
	scomp_state_t next_state;
	data          = ref_mem[ref_read_address]; // Word the memory shows now
	operand       = ref_ir[7:0];
	address       = ref_pc;                    // PC unless an operand is needed
	next_state    = fetch;
	left_reset_pc = 1'b0;
	if (in_reset)
		ref_read_address = ref_pc;             // Held at zero
	else
	begin
		case (ref_state)
			reset_pc:
			begin
				ref_pc        = '0;
				ref_acc       = '0;
				ref_out       = '0;
				left_reset_pc = 1'b1;
			end
			fetch:
			begin
				ref_ir     = data;
				ref_pc     = ref_pc + 8'd1;
				next_state = decode;
			end
			decode:
			begin
				address = operand; // Operand word prefetched
				case (ref_ir[15:8])
					opcode_add:           next_state = execute_add;
					opcode_store:         next_state = execute_store;
					opcode_load:          next_state = execute_load;
					opcode_jump:          next_state = execute_jump;
					opcode_jump_negative: next_state = execute_jump_n;
					opcode_out:           next_state = execute_out;
					default:              address = ref_pc; // Unknown, next fetch
				endcase
			end
			execute_add:    ref_acc = ref_acc + data; // Carry out lost
			execute_store:
			begin
				ref_mem[operand] = ref_acc;
				address          = operand;
				next_state       = execute_store2;
			end
			execute_store2:
			begin
				address    = operand;
				next_state = execute_store3;
			end
			execute_load:   ref_acc = data;
			execute_jump:
			begin
				ref_pc  = operand;
				address = operand;
			end
			execute_jump_n:
			begin
				if (ref_acc[15]) // Taken only when negative
				begin
					ref_pc  = operand;
					address = operand;
				end
			end
			execute_out:    ref_out = ref_acc;
			default:        ;
		endcase
		ref_state        = next_state;
		ref_read_address = address;
	end
endtask

function automatic word_t selected_value(input display_select_t sel);
	case (sel)
		3'd1:    return {8'h00, ref_pc};
		3'd2:    return ref_mem[ref_read_address];
		3'd3:    return ref_ir;
		3'd4:    return ref_out;
		default: return ref_acc; // Codes 0, 5, 6, 7
	endcase
endfunction

function automatic segments_t segment_pattern(input digit_t digit);
	return segment_table[digit];
endfunction

`endif

// File: dv/tb_scomp.sv
// Testbench for the accumulator computer
// Random readout select and reset pulses checked every cycle against a model

`timescale 1ns/1ps

module tb_scomp
	import scomp_pkg::*;
();

	localparam int clock_period = 8;     // ns
	localparam int reset_cycles = 16;
	localparam int test_cycles = 4000;
	localparam int watchdog_ns = test_cycles * clock_period + 2000; // Margin added

	logic            clock;
	logic            reset;
	display_select_t display_select;
	segments_t       hex0;
	segments_t       hex1;
	segments_t       hex2;
	segments_t       hex3;
	addr_t           program_counter;
	word_t           accumulator;
	word_t           memory_data;
	word_t           instruction_register;
	word_t           out_register;

	`include "scomp_model.svh"

	scomp_top dut_i (
		.clock                (clock),
		.reset                (reset),
		.display_select       (display_select),
		.hex0                 (hex0),
		.hex1                 (hex1),
		.hex2                 (hex2),
		.hex3                 (hex3),
		.program_counter      (program_counter),
		.accumulator          (accumulator),
		.memory_data          (memory_data),
		.instruction_register (instruction_register),
		.out_register         (out_register)
	);

	////////////////////////////////
	// Compare tasks
	////////////////////////////////
	task automatic compare_word(input string name, input word_t actual, input word_t expected);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: got %h, expected %h at %0t", name, actual, expected, $time);
			$display("Errors found");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic compare_addr(input string name, input addr_t actual, input addr_t expected);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: got %h, expected %h at %0t", name, actual, expected, $time);
			$display("Errors found");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic compare_segments(input string name, input segments_t actual,
		input segments_t expected);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: got %h, expected %h at %0t", name, actual, expected, $time);
			$display("Errors found");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Registers, memory read data and all four digits
	task automatic check_outputs();
		word_t shown;
		shown = selected_value(display_select);
		compare_addr("program_counter", program_counter, ref_pc);
		compare_word("accumulator", accumulator, ref_acc);
		compare_word("instruction_register", instruction_register, ref_ir);
		compare_word("out_register", out_register, ref_out);
		compare_word("memory_data", memory_data, ref_mem[ref_read_address]); // Store readback
		compare_segments("hex0", hex0, segment_pattern(shown[3:0]));
		compare_segments("hex1", hex1, segment_pattern(shown[7:4]));
		compare_segments("hex2", hex2, segment_pattern(shown[11:8]));
		compare_segments("hex3", hex3, segment_pattern(shown[15:12]));
		if (left_reset_pc) // First fetch after reset
		begin
			compare_word("accumulator after reset", accumulator, 16'h0000);
			compare_addr("program_counter after reset", program_counter, 8'h00);
			compare_word("out_register after reset", out_register, 16'h0000);
		end
	endtask

	initial
	begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	////////////////////////////////
	// Stimulus and checking
	////////////////////////////////
	initial
	begin : stimulus
		int reset_remaining;
		int select_hold;
		reset           = 1'b1;
		display_select  = '0;
		void'($urandom(32'ha342));
		load_program();
		restart_cycle();
		reset_remaining = reset_cycles;
		select_hold     = 0;
		for (int cycle = 0; cycle < test_cycles; cycle++)
		begin
			@(posedge clock);
			advance_cycle(reset); // Model follows the same edge
			#1;
			if (reset_remaining > 0)
			begin
				reset_remaining--;
				if (reset_remaining == 0)
					reset = 1'b0;
			end
			else if ($urandom_range(299, 0) == 0) // Occasional mid-run pulse
			begin
				reset           = 1'b1;
				reset_remaining = $urandom_range(4, 1);
				restart_cycle();
			end
			if (select_hold == 0)
			begin
				display_select = display_select_t'($urandom_range(7, 0));
				select_hold    = $urandom_range(6, 2);
			end
			else
				select_hold--;
			@(negedge clock); // Outputs settled
			check_outputs();
		end
		$display("No errors");
		$finish;
	end

	initial
	begin : watchdog
		#(watchdog_ns);
		$display("Timeout: the run did not end within %0d ns", watchdog_ns);
		$display("Errors found");
		$fatal(1, "Watchdog expired");
	end

endmodule

// File: program.hex
// One 16-bit word per line: opcode in the upper byte, operand address in the lower
// Opcodes 00 ADD, 01 ST, 02 LD, 03 JMP, 04 JNEG, 05 OUT; data words start at 18
0219 // LD counter
0018 // ADD step, wraps past 7fff
0119 // ST counter
0500 // OUT
0408 // JNEG to the undefined opcode
021c // LD 7fff
001c // ADD 7fff, overflows negative
0409 // JNEG, always taken here
0a00 // Undefined opcode, skipped
001a // ADD 8000, sign flips
011b // ST scratch
021b // LD scratch back
0500 // OUT
040f // JNEG, never taken here
0300 // JMP to start
0300 // JMP to start
@18
2345 // Step
0000 // Counter
8000 // Sign flip constant
0000 // Scratch
7fff // Largest positive

// File: list.f
+incdir+dv
src/scomp_pkg.sv
src/scomp_control.sv
src/address_unit.sv
src/accumulator_unit.sv
src/program_memory.sv
src/hex_display.sv
src/scomp_top.sv
dv/tb_scomp.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_scomp
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_scomp)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^No errors$"; then
	exit 0
fi
exit 1
